//--- isa_pkg.sv
// ==========================================================================
// Instruction set package for the 32-bit, 8-register CPU.
// Holds the basic types, the 7-bit opcodes and the instruction format union.
// ==========================================================================

package isa_pkg;

    typedef logic [31:0] word_t;      // data word
    typedef logic [2:0]  reg_addr_t;  // one of 8 registers
    typedef logic [15:0] imm16_t;     // immediate or memory/branch offset
    typedef logic [2:0]  alu_op_t;    // low opcode bits, fed straight to the ALU
    typedef logic [6:0]  op7_t;       // major opcode, instruction[31:25]

    localparam int unsigned BR_SHIFT = 2;  // branch offset counts words, pc counts bytes

    // don't-care opcode bits are encoded as 0
    localparam op7_t OP_LOAD  = 7'b1000000;
    localparam op7_t OP_STOR  = 7'b1000001;
    localparam op7_t OP_MOV   = 7'b0000000;
    localparam op7_t OP_MOVT  = 7'b0000001;
    localparam op7_t OP_CLR   = 7'b0000010;
    localparam op7_t OP_SET   = 7'b0000011;
    localparam op7_t OP_LSL   = 7'b0000100;
    localparam op7_t OP_LSR   = 7'b0000101;
    localparam op7_t OP_ADD   = 7'b0010001;  // immediate form, bit 28 is S
    localparam op7_t OP_SUB   = 7'b0010010;
    localparam op7_t OP_AND   = 7'b0010011;
    localparam op7_t OP_OR    = 7'b0010100;
    localparam op7_t OP_XOR   = 7'b0010101;
    localparam op7_t OP_ADDS  = 7'b0011001;
    localparam op7_t OP_SUBS  = 7'b0011010;
    localparam op7_t OP_ANDS  = 7'b0011011;
    localparam op7_t OP_ORS   = 7'b0011100;
    localparam op7_t OP_XORS  = 7'b0011101;
    localparam op7_t OP_ADD2  = 7'b0110001;  // register form, bit 30 set
    localparam op7_t OP_SUB2  = 7'b0110010;
    localparam op7_t OP_AND2  = 7'b0110011;
    localparam op7_t OP_OR2   = 7'b0110100;
    localparam op7_t OP_XOR2  = 7'b0110101;
    localparam op7_t OP_NOT   = 7'b0110110;
    localparam op7_t OP_ADDS2 = 7'b0111001;
    localparam op7_t OP_SUBS2 = 7'b0111010;
    localparam op7_t OP_ANDS2 = 7'b0111011;
    localparam op7_t OP_ORS2  = 7'b0111100;
    localparam op7_t OP_XORS2 = 7'b0111101;
    localparam op7_t OP_B     = 7'b1100000;
    localparam op7_t OP_BCOND = 7'b1100001;
    localparam op7_t OP_BR    = 7'b1100010;
    localparam op7_t OP_NOP   = 7'b1100100;
    localparam op7_t OP_HALT  = 7'b1101000;

    // one instruction word, four ways to read it
    typedef union packed {
        struct packed {
            op7_t       opcode;  // [31:25]
            reg_addr_t  rd;      // dest for LOAD, source for STOR
            reg_addr_t  ptr;     // pointer register
            logic [2:0] rsvd;
            imm16_t     offset;  // zero-extended
        } mem;
        struct packed {
            logic [2:0] op_hi;   // class bits
            logic       s;       // update cpsr flags
            alu_op_t    alu_op;
            reg_addr_t  rd;
            reg_addr_t  rs1;     // also the shift source for LSL/LSR
            logic [2:0] rsvd;
            imm16_t     imm;
        } dimm;
        struct packed {
            logic [2:0]  op_hi;
            logic        s;
            alu_op_t     alu_op;
            reg_addr_t   rd;
            reg_addr_t   rs1;
            reg_addr_t   rs2;
            logic [15:0] rsvd;
        } dreg;
        struct packed {
            op7_t       opcode;
            logic [3:0] cond;    // cond_pkg code
            logic [4:0] rsvd;
            imm16_t     offset;  // signed word offset
        } br;
    } instr_u;

endpackage

//--- cond_pkg.sv
// ==========================================================================
// Branch condition codes and the CPSR flag bit positions.
// ==========================================================================

package cond_pkg;

    typedef logic [3:0] cond_t;  // bcond condition field

    localparam cond_t COND_EQ = 4'd0;   // z set
    localparam cond_t COND_NE = 4'd1;   // z clear
    localparam cond_t COND_CS = 4'd2;   // c set
    localparam cond_t COND_CC = 4'd3;   // c clear
    localparam cond_t COND_MI = 4'd4;   // negative
    localparam cond_t COND_PL = 4'd5;   // positive or zero
    localparam cond_t COND_VS = 4'd6;   // overflow
    localparam cond_t COND_VC = 4'd7;   // no overflow
    localparam cond_t COND_HI = 4'd8;   // unsigned higher
    localparam cond_t COND_LS = 4'd9;   // unsigned lower or same
    localparam cond_t COND_GE = 4'd10;  // signed greater or equal
    localparam cond_t COND_LT = 4'd11;  // signed less than
    // codes 12..15 are reserved and never taken

    localparam int unsigned FLAG_N = 31;
    localparam int unsigned FLAG_Z = 30;
    localparam int unsigned FLAG_C = 29;
    localparam int unsigned FLAG_V = 28;

endpackage

//--- op_decode.sv
// ==========================================================================
// Opcode decoder. Turns the 7-bit opcode into one-hot class levels
// and keeps the sticky halt flag.
// ==========================================================================

module op_decode (
    input  logic            clk,
    input  logic            arst_n,
    input  isa_pkg::instr_u instruction,
    output logic            cls_load,
    output logic            cls_stor,
    output logic            cls_alu_imm,
    output logic            cls_alu_reg,
    output logic            cls_not,
    output logic            cls_mov,
    output logic            cls_movt,
    output logic            cls_lsl,
    output logic            cls_lsr,
    output logic            cls_clr,
    output logic            cls_set,
    output logic            cls_bcond,
    output logic            set_flags,
    output logic            illegal_op,
    output logic            halt_flag
);
    import isa_pkg::*;

    op7_t op;       // major opcode
    logic is_halt;

    assign op      = instruction.mem.opcode;
    assign is_halt = (op == OP_HALT);

    // sticky until reset, a HALT while already halted changes nothing
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halt_flag <= 1'b0;
        end else if (is_halt) begin
            halt_flag <= 1'b1;
        end
    end

    always_comb begin
        cls_load    = 1'b0;  // everything idle unless decoded below
        cls_stor    = 1'b0;
        cls_alu_imm = 1'b0;
        cls_alu_reg = 1'b0;
        cls_not     = 1'b0;
        cls_mov     = 1'b0;
        cls_movt    = 1'b0;
        cls_lsl     = 1'b0;
        cls_lsr     = 1'b0;
        cls_clr     = 1'b0;
        cls_set     = 1'b0;
        cls_bcond   = 1'b0;
        set_flags   = 1'b0;
        illegal_op  = 1'b0;
        if (!halt_flag) begin  // a halted core decodes nothing
            case (op)
                OP_LOAD:  cls_load = 1'b1;
                OP_STOR:  cls_stor = 1'b1;
                OP_MOV:   cls_mov  = 1'b1;
                OP_MOVT:  cls_movt = 1'b1;
                OP_LSL:   cls_lsl  = 1'b1;
                OP_LSR:   cls_lsr  = 1'b1;
                OP_CLR:   cls_clr  = 1'b1;
                OP_SET:   cls_set  = 1'b1;
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: cls_alu_imm = 1'b1;
                OP_ADDS, OP_SUBS, OP_ANDS, OP_ORS, OP_XORS: begin
                    cls_alu_imm = 1'b1;
                    set_flags   = 1'b1;  // S variant
                end
                OP_ADD2, OP_SUB2, OP_AND2, OP_OR2, OP_XOR2: cls_alu_reg = 1'b1;
                OP_ADDS2, OP_SUBS2, OP_ANDS2, OP_ORS2, OP_XORS2: begin
                    cls_alu_reg = 1'b1;
                    set_flags   = 1'b1;
                end
                OP_NOT:   cls_not   = 1'b1;
                OP_BCOND: cls_bcond = 1'b1;
                OP_B, OP_BR, OP_NOP, OP_HALT: ;  // no controls behind these
                default:  illegal_op = 1'b1;     // unlisted encoding
            endcase
        end
    end

endmodule

//--- regfile_ctrl.sv
// ==========================================================================
// Register file and ALU control. Picks the read/write registers, builds
// the decoder-side write data and drives the ALU operand controls.
// ==========================================================================

module regfile_ctrl (
    input  isa_pkg::instr_u    instruction,
    input  logic               cls_load,
    input  logic               cls_stor,
    input  logic               cls_alu_imm,
    input  logic               cls_alu_reg,
    input  logic               cls_not,
    input  logic               cls_mov,
    input  logic               cls_movt,
    input  logic               cls_lsl,
    input  logic               cls_lsr,
    input  logic               cls_clr,
    input  logic               cls_set,
    input  logic               set_flags,
    input  isa_pkg::word_t     reg1_val,
    input  isa_pkg::word_t     data_val,
    output isa_pkg::reg_addr_t read_addr1,
    output isa_pkg::reg_addr_t read_addr2,
    output isa_pkg::reg_addr_t write_addr,
    output isa_pkg::word_t     write_data,
    output logic               write_data_sel,
    output logic               write_enable,
    output logic               wr_cpsr,
    output isa_pkg::alu_op_t   opcode,
    output isa_pkg::word_t     operand2,
    output logic               ir_op
);
    import isa_pkg::*;

    imm16_t    imm;      // shared by MOV/MOVT/shift and ALU immediates
    reg_addr_t rd;       // dest, also STOR source
    reg_addr_t rs1;      // operand 1, mem pointer sits in the same bits
    reg_addr_t rs2;
    logic      alu_cls;  // result comes from the ALU

    assign imm = instruction.dimm.imm;
    assign rd  = instruction.dimm.rd;
    assign rs1 = instruction.dimm.rs1;
    assign rs2 = instruction.dreg.rs2;

    assign alu_cls = cls_alu_imm | cls_alu_reg | cls_not;

    always_comb begin
        read_addr1 = '0;
        read_addr2 = '0;
        write_addr = '0;
        if (cls_load) begin
            read_addr1 = instruction.mem.ptr;  // base pointer
            write_addr = instruction.mem.rd;
        end
        if (cls_stor) begin
            read_addr1 = instruction.mem.rd;   // value to store
            read_addr2 = instruction.mem.ptr;
        end
        if (cls_mov | cls_movt) begin
            read_addr1 = rd;                   // keeps the other half of rd
            write_addr = rd;
        end
        if (alu_cls | cls_lsl | cls_lsr) begin
            read_addr1 = rs1;
            write_addr = rd;
        end
        if (cls_alu_reg) begin
            read_addr2 = rs2;
        end
        if (cls_clr | cls_set) begin
            write_addr = rd;
        end
    end

    always_comb begin
        write_data = '0;  // ALU classes write through the ALU mux instead
        if (cls_load) write_data = data_val;
        if (cls_mov)  write_data = {reg1_val[31:16], imm};
        if (cls_movt) write_data = {imm, reg1_val[15:0]};
        if (cls_lsl)  write_data = reg1_val << imm;
        if (cls_lsr)  write_data = reg1_val >> imm;  // logical, zero fill
        if (cls_set)  write_data = '1;
    end

    assign write_enable = cls_load | alu_cls | cls_mov | cls_movt | cls_lsl | cls_lsr
                        | cls_clr | cls_set;
    assign write_data_sel = alu_cls;            // 1 picks the ALU result
    assign wr_cpsr  = set_flags;                // only S variants set this
    assign opcode   = alu_cls ? instruction.dimm.alu_op : '0;
    assign operand2 = cls_alu_imm ? {16'b0, imm} : '0;
    assign ir_op    = cls_alu_reg | cls_not;    // 1 takes reg2 into the ALU

endmodule

//--- mem_access.sv
// ==========================================================================
// Data memory access. Address, write data and enables for LOAD and STOR.
// ==========================================================================

module mem_access (
    input  isa_pkg::instr_u instruction,
    input  logic            cls_load,
    input  logic            cls_stor,
    input  isa_pkg::word_t  reg1_val,
    input  isa_pkg::word_t  reg2_val,
    output isa_pkg::word_t  data_addr,
    output isa_pkg::word_t  data_out,
    output logic            data_read,
    output logic            data_write
);
    import isa_pkg::*;

    word_t  base;    // pointer register value
    imm16_t offset;
    logic   active;

    assign offset = instruction.mem.offset;
    assign active = cls_load | cls_stor;

    // LOAD points with reg1, STOR with reg2 since reg1 holds the data
    assign base = cls_stor ? reg2_val : reg1_val;

    assign data_addr  = active ? base + {16'b0, offset} : '0;
    assign data_out   = cls_stor ? reg1_val : '0;
    assign data_read  = cls_load;
    assign data_write = cls_stor;

endmodule

//--- branch_unit.sv
// ==========================================================================
// Conditional branch unit. Checks the condition against the CPSR flags
// and forms the PC-relative target.
// ==========================================================================

module branch_unit (
    input  isa_pkg::instr_u instruction,
    input  logic            cls_bcond,
    input  isa_pkg::word_t  re_cpsr_val,
    input  isa_pkg::word_t  re_pc_val,
    output logic            wr_pc,
    output isa_pkg::word_t  wr_pc_val
);
    import isa_pkg::*;
    import cond_pkg::*;

    cond_t cond;
    logic  flag_n;
    logic  flag_z;
    logic  flag_c;
    logic  flag_v;
    logic  taken;   // condition holds
    word_t b_off;   // byte offset

    assign cond   = instruction.br.cond;
    assign flag_n = re_cpsr_val[FLAG_N];
    assign flag_z = re_cpsr_val[FLAG_Z];
    assign flag_c = re_cpsr_val[FLAG_C];
    assign flag_v = re_cpsr_val[FLAG_V];

    always_comb begin
        case (cond)
            COND_EQ: taken = flag_z;
            COND_NE: taken = !flag_z;
            COND_CS: taken = flag_c;
            COND_CC: taken = !flag_c;
            COND_MI: taken = flag_n;
            COND_PL: taken = !flag_n;
            COND_VS: taken = flag_v;
            COND_VC: taken = !flag_v;
            COND_HI: taken = !flag_z && flag_c;
            COND_LS: taken = !(!flag_z && flag_c);
            COND_GE: taken = (flag_n == flag_v);
            COND_LT: taken = (flag_n != flag_v);
            default: taken = 1'b0;  // reserved codes
        endcase
    end

    // sign extend then scale to bytes
    assign b_off = {{16{instruction.br.offset[15]}}, instruction.br.offset} << BR_SHIFT;

    assign wr_pc     = cls_bcond & taken;
    assign wr_pc_val = wr_pc ? re_pc_val + b_off : '0;

endmodule

//--- instr_decode.sv
// ==========================================================================
// Instruction decode stage top. Connects the opcode decoder, register
// file control, data memory access and branch unit.
// ==========================================================================

module instr_decode (
    input  logic               clk,
    input  logic               arst_n,
    input  isa_pkg::word_t     instruction,
    input  isa_pkg::word_t     reg1_val,
    input  isa_pkg::word_t     reg2_val,
    input  isa_pkg::word_t     data_val,
    input  isa_pkg::word_t     re_cpsr_val,
    input  isa_pkg::word_t     re_pc_val,
    output logic               halt_flag,
    output logic               illegal_op,
    output isa_pkg::reg_addr_t read_addr1,
    output isa_pkg::reg_addr_t read_addr2,
    output isa_pkg::reg_addr_t write_addr,
    output isa_pkg::word_t     write_data,
    output logic               write_data_sel,
    output logic               write_enable,
    output logic               wr_cpsr,
    output isa_pkg::word_t     data_addr,
    output logic               data_read,
    output logic               data_write,
    output isa_pkg::word_t     data_out,
    output isa_pkg::alu_op_t   opcode,
    output isa_pkg::word_t     operand2,
    output logic               ir_op,
    output isa_pkg::word_t     wr_pc_val,
    output logic               wr_pc
);
    import isa_pkg::*;

    instr_u instr;  // format view of the raw word
    logic   cls_load;
    logic   cls_stor;
    logic   cls_alu_imm;
    logic   cls_alu_reg;
    logic   cls_not;
    logic   cls_mov;
    logic   cls_movt;
    logic   cls_lsl;
    logic   cls_lsr;
    logic   cls_clr;
    logic   cls_set;
    logic   cls_bcond;
    logic   set_flags;

    assign instr = instr_u'(instruction);

    op_decode u_op_decode (
        .clk(clk), .arst_n(arst_n), .instruction(instr),
        .cls_load(cls_load), .cls_stor(cls_stor),
        .cls_alu_imm(cls_alu_imm), .cls_alu_reg(cls_alu_reg), .cls_not(cls_not),
        .cls_mov(cls_mov), .cls_movt(cls_movt), .cls_lsl(cls_lsl), .cls_lsr(cls_lsr),
        .cls_clr(cls_clr), .cls_set(cls_set), .cls_bcond(cls_bcond),
        .set_flags(set_flags), .illegal_op(illegal_op), .halt_flag(halt_flag)
    );

    regfile_ctrl u_regfile_ctrl (
        .instruction(instr), .cls_load(cls_load), .cls_stor(cls_stor),
        .cls_alu_imm(cls_alu_imm), .cls_alu_reg(cls_alu_reg), .cls_not(cls_not),
        .cls_mov(cls_mov), .cls_movt(cls_movt), .cls_lsl(cls_lsl), .cls_lsr(cls_lsr),
        .cls_clr(cls_clr), .cls_set(cls_set), .set_flags(set_flags),
        .reg1_val(reg1_val), .data_val(data_val),
        .read_addr1(read_addr1), .read_addr2(read_addr2), .write_addr(write_addr),
        .write_data(write_data), .write_data_sel(write_data_sel),
        .write_enable(write_enable), .wr_cpsr(wr_cpsr),
        .opcode(opcode), .operand2(operand2), .ir_op(ir_op)
    );

    mem_access u_mem_access (
        .instruction(instr), .cls_load(cls_load), .cls_stor(cls_stor),
        .reg1_val(reg1_val), .reg2_val(reg2_val),
        .data_addr(data_addr), .data_out(data_out),
        .data_read(data_read), .data_write(data_write)
    );

    branch_unit u_branch_unit (
        .instruction(instr), .cls_bcond(cls_bcond),
        .re_cpsr_val(re_cpsr_val), .re_pc_val(re_pc_val),
        .wr_pc(wr_pc), .wr_pc_val(wr_pc_val)
    );

endmodule

//--- tb_instr_decode.sv
// ==========================================================================
// Self-checking testbench for the instruction decode stage. Drives ALU,
// move/shift, memory, branch, no-op and halt instructions into the DUT.
// ==========================================================================

module tb_instr_decode;
    import isa_pkg::*;
    import cond_pkg::*;

    localparam int unsigned HALF_PERIOD = 20;
    localparam int unsigned RUN_LIMIT   = 40 * 5000;  // watchdog in time units
    localparam int unsigned HALT_WAIT   = 4;          // cycles allowed for halt_flag

    logic      clk;
    logic      arst_n;
    word_t     instruction;
    word_t     reg1_val;
    word_t     reg2_val;
    word_t     data_val;
    word_t     re_cpsr_val;
    word_t     re_pc_val;
    logic      halt_flag;
    logic      illegal_op;
    reg_addr_t read_addr1;
    reg_addr_t read_addr2;
    reg_addr_t write_addr;
    word_t     write_data;
    logic      write_data_sel;
    logic      write_enable;
    logic      wr_cpsr;
    word_t     data_addr;
    logic      data_read;
    logic      data_write;
    word_t     data_out;
    alu_op_t   opcode;
    word_t     operand2;
    logic      ir_op;
    word_t     wr_pc_val;
    logic      wr_pc;

    integer    seed;
    int        errors;
    int        checks;
    int        waited;
    op7_t      alu_ops[21];
    op7_t      mv_ops[6];
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    imm16_t    imm;
    word_t     exp_data;
    logic      taken;

    instr_decode dut0 (
        .clk(clk), .arst_n(arst_n), .instruction(instruction),
        .reg1_val(reg1_val), .reg2_val(reg2_val), .data_val(data_val),
        .re_cpsr_val(re_cpsr_val), .re_pc_val(re_pc_val),
        .halt_flag(halt_flag), .illegal_op(illegal_op),
        .read_addr1(read_addr1), .read_addr2(read_addr2), .write_addr(write_addr),
        .write_data(write_data), .write_data_sel(write_data_sel),
        .write_enable(write_enable), .wr_cpsr(wr_cpsr),
        .data_addr(data_addr), .data_read(data_read), .data_write(data_write),
        .data_out(data_out), .opcode(opcode), .operand2(operand2), .ir_op(ir_op),
        .wr_pc_val(wr_pc_val), .wr_pc(wr_pc)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // drives at negedge and returns mid low phase for sampling
    task automatic apply_instr(input word_t word);
        @(negedge clk);
        instruction = word;
        reg1_val    = $random(seed);
        reg2_val    = $random(seed);
        data_val    = $random(seed);
        re_cpsr_val = $random(seed);
        re_pc_val   = $random(seed);
        #(HALF_PERIOD / 2);
    endtask

    task automatic check_idle(input string name);
        check_value({name, " write_enable"}, 0, write_enable);
        check_value({name, " data_read"}, 0, data_read);
        check_value({name, " data_write"}, 0, data_write);
        check_value({name, " wr_pc"}, 0, wr_pc);
        check_value({name, " wr_cpsr"}, 0, wr_cpsr);
    endtask

    // condition rule on N Z C V
    function automatic logic cond_holds(input logic [3:0] cond, input word_t cpsr);
        logic n;
        logic z;
        logic c;
        logic v;
        n = cpsr[FLAG_N];
        z = cpsr[FLAG_Z];
        c = cpsr[FLAG_C];
        v = cpsr[FLAG_V];
        if (cond == COND_EQ || cond == COND_NE) return (cond == COND_EQ) ? z : !z;
        if (cond == COND_CS || cond == COND_CC) return (cond == COND_CS) ? c : !c;
        if (cond == COND_MI || cond == COND_PL) return (cond == COND_MI) ? n : !n;
        if (cond == COND_VS || cond == COND_VC) return (cond == COND_VS) ? v : !v;
        if (cond == COND_HI || cond == COND_LS) return (cond == COND_HI) ? (c && !z) : (z || !c);
        if (cond == COND_GE) return n == v;
        if (cond == COND_LT) return n != v;
        return 1'b0;  // 12..15
    endfunction

    initial begin
        #(RUN_LIMIT);
        $display("timeout: the run did not finish within %0d time units", RUN_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        instruction = {OP_NOP, 25'b0};
        reg1_val = '0;
        reg2_val = '0;
        data_val = '0;
        re_cpsr_val = '0;
        re_pc_val = '0;
        seed = 32'hcb31dd71;
        errors = 0;
        checks = 0;
        alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDS, OP_SUBS, OP_ANDS,
                    OP_ORS, OP_XORS, OP_ADD2, OP_SUB2, OP_AND2, OP_OR2, OP_XOR2, OP_NOT,
                    OP_ADDS2, OP_SUBS2, OP_ANDS2, OP_ORS2, OP_XORS2};
        mv_ops = '{OP_MOV, OP_MOVT, OP_LSL, OP_LSR, OP_CLR, OP_SET};
        for (int i = 0; i < 3; i++) @(negedge clk);  // reset held 3 cycles
        arst_n = 1'b1;
        check_value("reset halt_flag", 0, halt_flag);

        foreach (alu_ops[k]) begin  // bit 30 marks the register form and bit 28 the S bit
            for (int rep = 0; rep < 2; rep++) begin
                rd = $random(seed);
                rs1 = $random(seed);
                rs2 = $random(seed);
                imm = $random(seed);
                apply_instr({alu_ops[k], rd, rs1, rs2, imm});
                check_value("alu opcode", alu_ops[k][2:0], opcode);
                check_value("alu read_addr1", rs1, read_addr1);
                if (alu_ops[k][5] && alu_ops[k] != OP_NOT)
                    check_value("alu read_addr2", rs2, read_addr2);
                check_value("alu operand2", alu_ops[k][5] ? 32'd0 : {16'd0, imm}, operand2);
                check_value("alu ir_op", alu_ops[k][5], ir_op);
                check_value("alu write_data_sel", 1, write_data_sel);
                check_value("alu write_enable", 1, write_enable);
                check_value("alu write_addr", rd, write_addr);
                check_value("alu wr_cpsr", alu_ops[k][3], wr_cpsr);
                check_value("alu illegal_op", 0, illegal_op);
            end
        end

        foreach (mv_ops[k]) begin
            for (int rep = 0; rep < 3; rep++) begin
                rd = $random(seed);
                imm = $random(seed);
                if (mv_ops[k] == OP_LSL || mv_ops[k] == OP_LSR) imm = imm & 16'd31;
                apply_instr({mv_ops[k], rd, 3'd0, 3'd0, imm});
                case (k)
                    0: exp_data = {reg1_val[31:16], imm};  // MOV keeps the upper half
                    1: exp_data = {imm, reg1_val[15:0]};   // MOVT keeps the lower half
                    2: exp_data = reg1_val << imm;
                    3: exp_data = reg1_val >> imm;
                    4: exp_data = 32'h0000_0000;
                    default: exp_data = 32'hffff_ffff;
                endcase
                check_value("move write_data", exp_data, write_data);
                check_value("move write_data_sel", 0, write_data_sel);
                check_value("move write_enable", 1, write_enable);
                check_value("move write_addr", rd, write_addr);
            end
        end

        for (int rep = 0; rep < 4; rep++) begin
            rd = $random(seed);
            rs1 = $random(seed);
            imm = $random(seed);
            apply_instr({OP_LOAD, rd, rs1, 3'd0, imm});
            check_value("load data_addr", reg1_val + {16'd0, imm}, data_addr);
            check_value("load data_read", 1, data_read);
            check_value("load write_enable", 1, write_enable);
            check_value("load write_data", data_val, write_data);
            check_value("load write_addr", rd, write_addr);
            apply_instr({OP_STOR, rd, rs1, 3'd0, imm});
            check_value("stor data_addr", reg2_val + {16'd0, imm}, data_addr);
            check_value("stor data_out", reg1_val, data_out);
            check_value("stor data_write", 1, data_write);
            check_value("stor write_enable", 0, write_enable);
        end

        for (int cond = 0; cond < 16; cond++) begin
            for (int rep = 0; rep < 6; rep++) begin
                imm = $random(seed);
                apply_instr({OP_BCOND, cond[3:0], 5'd0, imm});
                taken = cond_holds(cond[3:0], re_cpsr_val);
                check_value("bcond wr_pc", taken, wr_pc);
                check_value("bcond wr_pc_val",
                            taken ? re_pc_val + ({{16{imm[15]}}, imm} << BR_SHIFT) : 32'd0,
                            wr_pc_val);
                check_value("bcond write_enable", 0, write_enable);
            end
        end

        apply_instr({OP_NOP, 25'h0});
        check_idle("nop");
        apply_instr({OP_B, 25'h1ab_cdef});
        check_idle("b");
        apply_instr({OP_BR, 25'h0f0_1234});
        check_idle("br");
        check_value("br illegal_op", 0, illegal_op);
        apply_instr({7'b1111111, 25'h0});  // no such encoding
        check_value("unlisted illegal_op", 1, illegal_op);
        check_idle("unlisted");

        apply_instr({OP_HALT, 25'h0});
        check_value("halt before edge", 0, halt_flag);
        waited = 0;
        while (!halt_flag && waited < HALT_WAIT) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (halt_flag) else begin
            errors++;
            $display("halt_flag never rose within %0d cycles after HALT", HALT_WAIT);
        end
        check_value("halt latency", 1, waited);
        apply_instr({OP_ADDS2, 3'd2, 3'd3, 3'd4, 16'h0055});
        check_idle("halted add");
        check_value("halted read_addr1", 0, read_addr1);
        check_value("halted read_addr2", 0, read_addr2);
        apply_instr({OP_NOP, 25'h0});
        check_value("halt sticky", 1, halt_flag);

        @(negedge clk);
        arst_n = 1'b0;  // only reset clears the halt
        #(HALF_PERIOD / 2);
        check_value("halt cleared", 0, halt_flag);
        for (int i = 0; i < 3; i++) @(negedge clk);
        arst_n = 1'b1;
        apply_instr({OP_ADD, 3'd1, 3'd2, 3'd0, 16'h0007});
        check_value("post reset write_enable", 1, write_enable);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- instr_decode.f
isa_pkg.sv
cond_pkg.sv
op_decode.sv
regfile_ctrl.sv
mem_access.sv
branch_unit.sv
instr_decode.sv
tb_instr_decode.sv

//--- Bender.yml
package:
  name: instr_decode

sources:
  - isa_pkg.sv
  - cond_pkg.sv
  - op_decode.sv
  - regfile_ctrl.sv
  - mem_access.sv
  - branch_unit.sv
  - instr_decode.sv
  - target: test
    files:
      - tb_instr_decode.sv
